// ==== common/eth_rx_pkg.sv ====
package eth_rx_pkg;

    // Gearbox side of the lane
    localparam int WORD_WIDTH   = 32;
    localparam int HEADER_WIDTH = 2;

    // One 64b/66b block, payload only
    localparam int BLOCK_WIDTH  = 2 * WORD_WIDTH;

    // 64b/66b sync header codes
    // Only 01 and 10 are legal on the line, the other two mark a bad header
    typedef enum logic [HEADER_WIDTH-1:0] {
        SH_INVALID_00 = 2'b00,
        SH_DATA       = 2'b01,   // Eight data octets
        SH_CTRL       = 2'b10,   // Block type field follows
        SH_INVALID_11 = 2'b11
    } sync_header_e;

    // Block lock states
    typedef enum logic [1:0] {
        LOCK_INIT = 2'd0,        // Out of reset, waiting for a first block
        TEST_SH   = 2'd1,        // Unlocked, testing headers
        LOCKED    = 2'd2,
        SLIP      = 2'd3         // One cycle, asks the gearbox to shift by a bit
    } sync_state_e;

    // Codes that a receiver may accept
    function automatic logic sh_is_valid(input sync_header_e sh);
        logic ok;
        case (sh)
            SH_DATA, SH_CTRL: ok = 1'b1;
            default:          ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage

// ==== block_sync/block_sync_fsm.sv ====
`timescale 1ns/1ns

module block_sync_fsm
    import eth_rx_pkg::*;
(
    input  logic clk_gtx_rx,
    input  logic i_arst_n,

    input  logic i_block_strobe,
    input  logic i_window_done,
    input  logic i_invalid_limit,

    output logic o_rxslip,
    output logic o_block_lock,
    output logic o_locked_cnt,
    output logic o_clear
);

    sync_state_e state;
    sync_state_e state_next;

    // Moves only on a strobed block, except SLIP which always leaves
    always_comb begin
        state_next = state;
        case (state)
            LOCK_INIT: begin
                if (i_block_strobe) begin
                    state_next = TEST_SH;   // First block already counted
                end
            end

            TEST_SH: begin
                if (i_block_strobe) begin
                    if (i_invalid_limit) begin
                        state_next = SLIP;  // Limit is a single bad header here
                    end else if (i_window_done) begin
                        state_next = LOCKED;
                    end
                end
            end

            LOCKED: begin
                // A clean window end just keeps the lock
                if (i_block_strobe && i_invalid_limit) begin
                    state_next = SLIP;
                end
            end

            SLIP: begin
                state_next = TEST_SH;
            end

            default: begin
                state_next = LOCK_INIT;
            end
        endcase
    end

    always_ff @(posedge clk_gtx_rx or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= LOCK_INIT;
        end else begin
            state <= state_next;
        end
    end

    // Moore outputs
    always_comb begin
        o_rxslip     = (state == SLIP);
        o_clear      = (state == SLIP);     // Window restarts with the slip
        o_block_lock = (state == LOCKED);
        o_locked_cnt = (state == LOCKED);   // Selects the bad-header limit
    end

endmodule

// ==== block_sync/sh_window_counter.sv ====
`timescale 1ns/1ns

module sh_window_counter #(
    parameter int SH_WINDOW        = 64,
    parameter int SH_INVALID_LIMIT = 16
) (
    input  logic clk_gtx_rx,
    input  logic i_arst_n,

    input  logic i_block_strobe,
    input  logic i_sh_valid,
    input  logic i_locked,
    input  logic i_clear,

    output logic o_window_done,
    output logic o_invalid_limit
);

    localparam int BLK_W = (SH_WINDOW > 1) ? $clog2(SH_WINDOW + 1) : 1;
    localparam int BAD_W = (SH_INVALID_LIMIT > 1) ? $clog2(SH_INVALID_LIMIT + 1) : 1;

    logic [BLK_W-1:0] blk_cnt;      // Blocks seen so far in the window
    logic [BAD_W-1:0] bad_cnt;      // Bad headers so far in the window
    logic [BAD_W-1:0] bad_cnt_inc;
    logic [BAD_W-1:0] active_limit;

    assign bad_cnt_inc  = bad_cnt + 1'b1;
    assign active_limit = i_locked ? BAD_W'(SH_INVALID_LIMIT) : BAD_W'(1);

    // Both flags already include the block on the strobe
    assign o_window_done   = i_block_strobe && (blk_cnt == BLK_W'(SH_WINDOW - 1));
    assign o_invalid_limit = i_block_strobe && !i_sh_valid && (bad_cnt_inc >= active_limit);

    always_ff @(posedge clk_gtx_rx or negedge i_arst_n) begin
        if (!i_arst_n) begin
            blk_cnt <= '0;
            bad_cnt <= '0;
        end else if (i_clear || o_window_done || o_invalid_limit) begin
            blk_cnt <= '0;
            bad_cnt <= '0;
        end else if (i_block_strobe) begin
            blk_cnt <= blk_cnt + 1'b1;
            if (!i_sh_valid) begin
                bad_cnt <= bad_cnt_inc;
            end
        end
    end

endmodule

// ==== logic/block_assembler.sv ====
`timescale 1ns/1ns

module block_assembler
    import eth_rx_pkg::*;
(
    input  logic                    clk_gtx_rx,
    input  logic                    i_arst_n,

    // From the gearbox
    input  logic [WORD_WIDTH-1:0]   i_rx_data,
    input  logic                    i_rx_data_valid,
    input  logic [HEADER_WIDTH-1:0] i_rx_header,
    input  logic                    i_rx_header_valid,

    output logic                    o_block_valid,
    output sync_header_e            o_block_header,
    output logic [BLOCK_WIDTH-1:0]  o_block_data,
    output logic                    o_sh_valid
);

    logic                  pending;       // First half of a block is held
    logic [WORD_WIDTH-1:0] first_word;
    sync_header_e          first_header;
    logic                  word_first;
    logic                  word_second;

    // Stalls are words with the data valid low
    assign word_first  = i_rx_data_valid && i_rx_header_valid;
    assign word_second = i_rx_data_valid && !i_rx_header_valid && pending;

    always_ff @(posedge clk_gtx_rx or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending       <= 1'b0;
            o_block_valid <= 1'b0;
        end else begin
            o_block_valid <= word_second;
            if (word_first) begin
                pending <= 1'b1;        // Any open block is dropped here
            end else if (word_second) begin
                pending <= 1'b0;
            end
        end
    end

    // Header arrives with the first word
    always_ff @(posedge clk_gtx_rx) begin
        if (word_first) begin
            first_word   <= i_rx_data;
            first_header <= sync_header_e'(i_rx_header);
        end
    end

    always_ff @(posedge clk_gtx_rx) begin
        if (word_second) begin
            o_block_data   <= {first_word, i_rx_data};  // First word in the upper half
            o_block_header <= first_header;
            o_sh_valid     <= sh_is_valid(first_header);
        end
    end

endmodule

// ==== logic/block_type_stats.sv ====
`timescale 1ns/1ns

module block_type_stats
    import eth_rx_pkg::*;
#(
    parameter int STAT_WIDTH = 16
) (
    input  logic                  clk_gtx_rx,
    input  logic                  i_arst_n,

    input  logic                  i_block_strobe,
    input  sync_header_e          i_block_header,
    input  logic                  i_sh_valid,
    input  logic                  i_block_lock,

    output logic [STAT_WIDTH-1:0] o_data_block_count,
    output logic [STAT_WIDTH-1:0] o_ctrl_block_count
);

    logic count_en;

    // Lock level as it stands at the strobe
    assign count_en = i_block_strobe && i_block_lock && i_sh_valid;

    always_ff @(posedge clk_gtx_rx or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_data_block_count <= '0;
            o_ctrl_block_count <= '0;
        end else if (count_en) begin
            case (i_block_header)
                SH_DATA: begin
                    if (o_data_block_count != '1) begin     // Saturate
                        o_data_block_count <= o_data_block_count + 1'b1;
                    end
                end
                SH_CTRL: begin
                    if (o_ctrl_block_count != '1) begin
                        o_ctrl_block_count <= o_ctrl_block_count + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/eth_rx_frontend.sv ====
`timescale 1ns/1ns

module eth_rx_frontend
    import eth_rx_pkg::*;
#(
    parameter int SH_WINDOW        = 64,
    parameter int SH_INVALID_LIMIT = 16,
    parameter int STAT_WIDTH       = 16
) (
    input  logic                    clk_gtx_rx,
    input  logic                    i_arst_n,

    // Gearbox output
    input  logic [WORD_WIDTH-1:0]   i_rx_data,
    input  logic                    i_rx_data_valid,
    input  logic [HEADER_WIDTH-1:0] i_rx_header,
    input  logic                    i_rx_header_valid,

    output logic                    o_block_valid,
    output sync_header_e            o_block_header,
    output logic [BLOCK_WIDTH-1:0]  o_block_data,
    output logic                    o_rxslip,        // Back to the gearbox
    output logic                    o_block_lock,
    output logic [STAT_WIDTH-1:0]   o_data_block_count,
    output logic [STAT_WIDTH-1:0]   o_ctrl_block_count
);

    logic sh_valid;
    logic window_done;
    logic invalid_limit;
    logic locked_cnt;
    logic win_clear;

    block_assembler block_assembler_inst (
        .clk_gtx_rx        (clk_gtx_rx),
        .i_arst_n          (i_arst_n),
        .i_rx_data         (i_rx_data),
        .i_rx_data_valid   (i_rx_data_valid),
        .i_rx_header       (i_rx_header),
        .i_rx_header_valid (i_rx_header_valid),
        .o_block_valid     (o_block_valid),
        .o_block_header    (o_block_header),
        .o_block_data      (o_block_data),
        .o_sh_valid        (sh_valid)
    );

    // Header bookkeeping per window
    sh_window_counter #(
        .SH_WINDOW        (SH_WINDOW),
        .SH_INVALID_LIMIT (SH_INVALID_LIMIT)
    ) sh_window_counter_inst (
        .clk_gtx_rx      (clk_gtx_rx),
        .i_arst_n        (i_arst_n),
        .i_block_strobe  (o_block_valid),
        .i_sh_valid      (sh_valid),
        .i_locked        (locked_cnt),
        .i_clear         (win_clear),
        .o_window_done   (window_done),
        .o_invalid_limit (invalid_limit)
    );

    block_sync_fsm block_sync_fsm_inst (
        .clk_gtx_rx      (clk_gtx_rx),
        .i_arst_n        (i_arst_n),
        .i_block_strobe  (o_block_valid),
        .i_window_done   (window_done),
        .i_invalid_limit (invalid_limit),
        .o_rxslip        (o_rxslip),
        .o_block_lock    (o_block_lock),
        .o_locked_cnt    (locked_cnt),
        .o_clear         (win_clear)
    );

    block_type_stats #(
        .STAT_WIDTH (STAT_WIDTH)
    ) block_type_stats_inst (
        .clk_gtx_rx         (clk_gtx_rx),
        .i_arst_n           (i_arst_n),
        .i_block_strobe     (o_block_valid),
        .i_block_header     (o_block_header),
        .i_sh_valid         (sh_valid),
        .i_block_lock       (o_block_lock),
        .o_data_block_count (o_data_block_count),
        .o_ctrl_block_count (o_ctrl_block_count)
    );

endmodule

// ==== tb/eth_rx_frontend_properties.sv ====
`timescale 1ns/1ns

module eth_rx_frontend_properties (
    input logic clk_gtx_rx,
    input logic i_arst_n,
    input logic o_block_valid,
    input logic o_rxslip,
    input logic o_block_lock
);

    int fail_count = 0;

    // Slip is a single cycle request
    assert property (@(posedge clk_gtx_rx) disable iff (!i_arst_n)
        o_rxslip |=> !o_rxslip)
    else begin
        $error("o_rxslip high for two cycles");
        fail_count++;
    end

    // Blocks are at least two cycles apart
    assert property (@(posedge clk_gtx_rx) disable iff (!i_arst_n)
        o_block_valid |=> !o_block_valid)
    else begin
        $error("o_block_valid high for two cycles");
        fail_count++;
    end

    // A slip always goes back to testing first
    assert property (@(posedge clk_gtx_rx) disable iff (!i_arst_n)
        $rose(o_block_lock) |-> !$past(o_rxslip))
    else begin
        $error("o_block_lock rose right after o_rxslip");
        fail_count++;
    end

endmodule

bind eth_rx_frontend eth_rx_frontend_properties eth_rx_frontend_properties_inst (
    .clk_gtx_rx    (clk_gtx_rx),
    .i_arst_n      (i_arst_n),
    .o_block_valid (o_block_valid),
    .o_rxslip      (o_rxslip),
    .o_block_lock  (o_block_lock)
);

// ==== tb/eth_rx_frontend_tb.sv ====
`timescale 1ns/1ns

module eth_rx_frontend_tb;
    import eth_rx_pkg::*;

    localparam int SH_WINDOW        = 8;
    localparam int SH_INVALID_LIMIT = 3;
    localparam int STAT_WIDTH       = 4;
    localparam int MAX_STALL        = 3;
    localparam int MAX_ENTRIES      = 64;
    localparam int STAT_MAX         = (1 << STAT_WIDTH) - 1;

    logic                    clk_gtx_rx;
    logic                    i_arst_n;
    logic [WORD_WIDTH-1:0]   i_rx_data;
    logic                    i_rx_data_valid;
    logic [HEADER_WIDTH-1:0] i_rx_header;
    logic                    i_rx_header_valid;
    logic                    o_block_valid;
    sync_header_e            o_block_header;
    logic [BLOCK_WIDTH-1:0]  o_block_data;
    logic                    o_rxslip;
    logic                    o_block_lock;
    logic [STAT_WIDTH-1:0]   o_data_block_count;
    logic [STAT_WIDTH-1:0]   o_ctrl_block_count;

    // Stimulus table, one block per entry
    logic [1:0] tbl_header [MAX_ENTRIES];
    int         tbl_stall  [MAX_ENTRIES];
    bit         tbl_misalign [MAX_ENTRIES];
    int         num_entries;

    // Reference model state (0 init, 1 testing, 2 locked)
    int ref_state;
    int ref_blk_cnt;
    int ref_bad_cnt;
    int ref_data_cnt;
    int ref_ctrl_cnt;
    bit ref_slip;

    int cycle_count;
    int cycle_limit;

    eth_rx_frontend #(
        .SH_WINDOW        (SH_WINDOW),
        .SH_INVALID_LIMIT (SH_INVALID_LIMIT),
        .STAT_WIDTH       (STAT_WIDTH)
    ) eth_rx_frontend_inst (
        .clk_gtx_rx         (clk_gtx_rx),
        .i_arst_n           (i_arst_n),
        .i_rx_data          (i_rx_data),
        .i_rx_data_valid    (i_rx_data_valid),
        .i_rx_header        (i_rx_header),
        .i_rx_header_valid  (i_rx_header_valid),
        .o_block_valid      (o_block_valid),
        .o_block_header     (o_block_header),
        .o_block_data       (o_block_data),
        .o_rxslip           (o_rxslip),
        .o_block_lock       (o_block_lock),
        .o_data_block_count (o_data_block_count),
        .o_ctrl_block_count (o_ctrl_block_count)
    );

    always #50 clk_gtx_rx = ~clk_gtx_rx;

    // Each entry takes at most 6 cycles plus its stall
    always @(posedge clk_gtx_rx) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input logic [1:0] hdr, input bit mis);
        tbl_header[num_entries]   = hdr;
        tbl_stall[num_entries]    = $urandom % (MAX_STALL + 1);
        tbl_misalign[num_entries] = mis;
        num_entries++;
    endtask

    task automatic drive_word(input logic dv, input logic hv, input logic [1:0] hdr,
                              input logic [WORD_WIDTH-1:0] data);
        @(posedge clk_gtx_rx);
        i_rx_data_valid   <= dv;
        i_rx_header_valid <= hv;
        i_rx_header       <= hdr;
        i_rx_data         <= data;
    endtask

    // Applies the block rules to one strobed block
    task automatic model_block(input logic [1:0] hdr);
        bit good;
        bit done;
        bit limit;
        int active;
        good   = (hdr == 2'b01) || (hdr == 2'b10);
        active = (ref_state == 2) ? SH_INVALID_LIMIT : 1;
        done   = (ref_blk_cnt == SH_WINDOW - 1);
        limit  = !good && (ref_bad_cnt + 1 >= active);
        if (ref_state == 2 && good) begin
            if (hdr == 2'b01 && ref_data_cnt < STAT_MAX) ref_data_cnt++;
            if (hdr == 2'b10 && ref_ctrl_cnt < STAT_MAX) ref_ctrl_cnt++;
        end
        ref_slip = 0;
        if (ref_state == 0) begin
            ref_state = 1;
        end else if (limit) begin
            ref_slip  = 1;
            ref_state = 1;          // Back to testing after the slip cycle
        end else if (ref_state == 1 && done) begin
            ref_state = 2;
        end
        if (done || limit || ref_slip) begin
            ref_blk_cnt = 0;
            ref_bad_cnt = 0;
        end else begin
            ref_blk_cnt++;
            if (!good) ref_bad_cnt++;
        end
    endtask

    task automatic apply_entry(input int idx);
        logic [WORD_WIDTH-1:0] w0;
        logic [WORD_WIDTH-1:0] w1;
        w0 = $urandom;
        w1 = $urandom;
        if (tbl_misalign[idx]) begin
            drive_word(1'b1, 1'b1, 2'($urandom), $urandom);  // Partial block, dropped
        end
        drive_word(1'b1, 1'b1, tbl_header[idx], w0);
        repeat (tbl_stall[idx]) drive_word(1'b0, 1'b0, 2'($urandom), $urandom);
        drive_word(1'b1, 1'b0, 2'b00, w1);
        drive_word(1'b0, 1'b0, 2'b00, '0);
        @(negedge clk_gtx_rx);
        compare_value("o_block_valid", o_block_valid, 1);
        compare_value("o_block_data", o_block_data, {w0, w1});
        compare_value("o_block_header", o_block_header, tbl_header[idx]);
        model_block(tbl_header[idx]);
        drive_word(1'b0, 1'b0, 2'b00, '0);
        @(negedge clk_gtx_rx);
        compare_value("o_block_valid", o_block_valid, 0);
        compare_value("o_rxslip", o_rxslip, ref_slip);
        compare_value("o_block_lock", o_block_lock, (ref_state == 2) && !ref_slip);
        compare_value("o_data_block_count", o_data_block_count, ref_data_cnt);
        compare_value("o_ctrl_block_count", o_ctrl_block_count, ref_ctrl_cnt);
    endtask

    initial begin
        void'($urandom(32'hd3a7));
        clk_gtx_rx        = 1'b0;
        i_arst_n          = 1'b0;
        i_rx_data         = '0;
        i_rx_data_valid   = 1'b0;
        i_rx_header       = '0;
        i_rx_header_valid = 1'b0;
        cycle_count  = 0;
        num_entries  = 0;
        ref_state    = 0;
        ref_blk_cnt  = 0;
        ref_bad_cnt  = 0;
        ref_data_cnt = 0;
        ref_ctrl_cnt = 0;
        ref_slip     = 0;

        // Short run, then a bad header and a slip
        add_entry(2'b01, 0);
        add_entry(2'b10, 1);
        add_entry(2'b01, 0);
        add_entry(2'b00, 0);
        // Eight good headers give lock
        for (int i = 0; i < 8; i++) add_entry((i % 3 == 0) ? 2'b10 : 2'b01, i == 4);
        // Two bad in one window keep the lock
        add_entry(2'b11, 0);
        add_entry(2'b01, 0);
        add_entry(2'b01, 0);
        add_entry(2'b10, 0);
        add_entry(2'b00, 1);
        add_entry(2'b01, 0);
        add_entry(2'b10, 0);
        add_entry(2'b01, 0);
        // Enough of each type to saturate
        for (int i = 0; i < 32; i++) add_entry(i[0] ? 2'b10 : 2'b01, i % 7 == 3);
        // Three bad in one window lose the lock
        add_entry(2'b00, 0);
        add_entry(2'b01, 0);
        add_entry(2'b11, 0);
        add_entry(2'b10, 0);
        add_entry(2'b00, 0);
        add_entry(2'b01, 0);    // Unlocked, not counted
        add_entry(2'b10, 0);

        cycle_limit = 10 + num_entries * (6 + MAX_STALL) + 50;

        repeat (10) @(posedge clk_gtx_rx);
        i_arst_n <= 1'b1;
        @(negedge clk_gtx_rx);
        compare_value("o_block_valid", o_block_valid, 0);
        compare_value("o_rxslip", o_rxslip, 0);
        compare_value("o_block_lock", o_block_lock, 0);
        compare_value("o_data_block_count", o_data_block_count, 0);
        compare_value("o_ctrl_block_count", o_ctrl_block_count, 0);

        for (int i = 0; i < num_entries; i++) begin
            apply_entry(i);
        end

        if (eth_rx_frontend_inst.eth_rx_frontend_properties_inst.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/eth_rx_pkg.sv
block_sync/block_sync_fsm.sv
block_sync/sh_window_counter.sv
logic/block_assembler.sv
logic/block_type_stats.sv
logic/eth_rx_frontend.sv
tb/eth_rx_frontend_properties.sv
tb/eth_rx_frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eth_rx_frontend_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
